// File: hw/render_pkg.sv
package render_pkg;

    // Datapath widths
    localparam int coord_w = 11;
    localparam int color_w = 3;
    localparam int rgb_w   = 6;

    // Palette indices shared by the sprite ROM and the obstacle plaque
    localparam logic [color_w-1:0] color_transparent = 3'd0;
    localparam logic [color_w-1:0] color_goose_body  = 3'd1;
    localparam logic [color_w-1:0] color_black       = 3'd2;
    localparam logic [color_w-1:0] color_beak        = 3'd3;
    localparam logic [color_w-1:0] color_gold        = 3'd4;
    localparam logic [color_w-1:0] color_white       = 3'd5;
    localparam logic [color_w-1:0] color_red         = 3'd6;

    // Bit positions in the registered layer vector
    localparam int layer_goose    = 0;
    localparam int layer_obstacle = 1;
    localparam int layer_floor    = 2;
    localparam int layer_sky      = 3;
    localparam int layer_dots     = 4;
    localparam int layer_count    = 5;

    // Backdrop colours as {R, G, B}
    localparam logic [rgb_w-1:0] sky_rgb   = {2'd0, 2'd3, 2'd3};
    localparam logic [rgb_w-1:0] floor_rgb = {2'd1, 2'd1, 2'd1};
    localparam logic [rgb_w-1:0] dot_rgb   = {2'd2, 2'd2, 2'd2};

    // Screen and sprite geometry in pixels
    localparam logic [coord_w-1:0] screen_width    = 11'd640;
    localparam logic [coord_w-1:0] goose_x         = 11'd64;
    // 16x16 ROM drawn at 2x scale
    localparam logic [coord_w-1:0] goose_size_px   = 11'd32;
    localparam logic [coord_w-1:0] obstacle_w      = 11'd40;
    localparam logic [coord_w-1:0] obstacle_h      = 11'd48;
    // Start offset keeps the gap small when the first obstacle wraps
    localparam logic [coord_w-1:0] obstacle_offset = 11'd334;

    // Index to {R[1:0], G[1:0], B[1:0]}
    function automatic logic [rgb_w-1:0] palette(input logic [color_w-1:0] idx);
        logic [rgb_w-1:0] rgb;
        case (idx)
            color_goose_body: rgb = {2'd2, 2'd2, 2'd1};
            color_black:      rgb = {2'd0, 2'd0, 2'd0};
            color_beak:       rgb = {2'd3, 2'd2, 2'd1};
            color_gold:       rgb = {2'd3, 2'd2, 2'd0};
            color_white:      rgb = {2'd3, 2'd3, 2'd3};
            color_red:        rgb = {2'd2, 2'd0, 2'd0};
            default:          rgb = '0;
        endcase
        return rgb;
    endfunction

endpackage

// File: hw/backdrop.sv
module backdrop #(
    parameter logic [render_pkg::coord_w-1:0] FLOOR_Y
) (
    input  logic [9:0]                      haddr,
    input  logic [9:0]                      vaddr,
    input  logic [render_pkg::coord_w-1:0]  scrolladdr,
    input  logic                            display_on,
    output logic                            sky_hit,
    output logic                            floor_hit,
    output logic                            dot_hit
);
    import render_pkg::*;

    logic [coord_w-1:0] vaddr_ext;
    logic               above_floor;
    logic               on_floor_line;
    logic [3:0]         dot_phase;

    assign vaddr_ext = {1'b0, vaddr};

    assign above_floor   = vaddr_ext < FLOOR_Y;
    assign on_floor_line = vaddr_ext == FLOOR_Y;

    // Only the low four bits of haddr + scroll matter for a 16 pixel pattern
    assign dot_phase = haddr[3:0] + scrolladdr[3:0];

    assign sky_hit   = display_on && above_floor;
    assign floor_hit = display_on && !above_floor;

    // Four lit pixels out of every sixteen on the top floor row
    assign dot_hit = display_on && on_floor_line &&
                     (dot_phase >= 4'd2) && (dot_phase <= 4'd5);

endmodule

// File: hw/goose_sprite.sv
module goose_sprite #(
    parameter logic [render_pkg::coord_w-1:0] FLOOR_Y
) (
    input  logic [9:0]                    haddr,
    input  logic [9:0]                    vaddr,
    input  logic [6:0]                    jump_pos,
    input  logic                          display_on,
    input  logic                          game_start_blink,
    input  logic                          game_over,
    output logic                          goose_hit,
    output logic [render_pkg::rgb_w-1:0]  goose_rgb
);
    import render_pkg::*;

    logic [coord_w-1:0] haddr_ext;
    logic [coord_w-1:0] vaddr_ext;
    logic [coord_w-1:0] goose_top;
    logic [coord_w-1:0] row_offset;
    logic               in_bounds;
    logic [3:0]         rom_x;
    logic [3:0]         rom_y;
    logic [color_w-1:0] pixel_idx;
    logic [color_w-1:0] color_idx;

    // One 3-bit index per pixel, leftmost pixel in the top bits
    function automatic logic [color_w-1:0] goose_rom(input logic [3:0] row, input logic [3:0] col);
        logic [16*color_w-1:0] bits;
        int unsigned           shift;
        case (row)
            4'd2:    bits = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_000;
            4'd3,
            4'd4,
            4'd5:    bits = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_011;
            4'd6,
            4'd7,
            4'd8,
            4'd9:    bits = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_000_000_000;
            4'd10,
            4'd11,
            4'd12,
            4'd13,
            4'd14:   bits = 48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000;
            4'd15:   bits = 48'b000_000_000_000_010_010_000_000_000_010_010_000_000_000_000_000;
            default: bits = '0;
        endcase
        shift = (15 - int'(col)) * color_w;
        return bits[shift +: color_w];
    endfunction

    assign haddr_ext = {1'b0, haddr};
    assign vaddr_ext = {1'b0, vaddr};

    // Jumping lifts the sprite above its resting row
    assign goose_top  = FLOOR_Y - goose_size_px - {4'd0, jump_pos};
    assign row_offset = vaddr_ext - goose_top;

    assign in_bounds = (haddr_ext >= goose_x) && (haddr_ext < goose_x + goose_size_px) &&
                       (vaddr_ext >= goose_top) && (vaddr_ext < goose_top + goose_size_px);

    // Dropping bit 0 doubles every ROM pixel in both directions
    assign rom_x = haddr[4:1];
    assign rom_y = row_offset[4:1];

    assign pixel_idx = goose_rom(rom_y, rom_x);

    assign goose_hit = display_on && game_start_blink && in_bounds &&
                       (pixel_idx != color_transparent);

    // Whole goose turns red once the game is lost
    assign color_idx = game_over ? color_red : pixel_idx;
    assign goose_rgb = palette(color_idx);

endmodule

// File: hw/obstacle_plaque.sv
module obstacle_plaque #(
    parameter logic [render_pkg::coord_w-1:0] FLOOR_Y,
    parameter logic [render_pkg::coord_w-1:0] OBSTACLE_GAP
) (
    input  logic [9:0]                      haddr,
    input  logic [9:0]                      vaddr,
    input  logic [render_pkg::coord_w-1:0]  scrolladdr,
    input  logic                            display_on,
    input  logic                            obstacle_active,
    output logic                            obstacle_hit,
    output logic [render_pkg::rgb_w-1:0]    obstacle_rgb
);
    import render_pkg::*;

    logic [coord_w-1:0] haddr_ext;
    logic [coord_w-1:0] vaddr_ext;
    logic [coord_w-1:0] obstacle_top;
    logic [coord_w-1:0] obs1_x;
    logic [coord_w-1:0] obs2_x;
    logic [coord_w-1:0] sel_x;
    logic [coord_w-1:0] local_x;
    logic [coord_w-1:0] local_y;
    logic               rows_hit;
    logic               obs1_in;
    logic               obs2_in;
    logic               outline;

    assign haddr_ext = {1'b0, haddr};
    assign vaddr_ext = {1'b0, vaddr};

    assign obstacle_top = FLOOR_Y - obstacle_h;

    // Left edges move left as the scroll grows and wrap at 2048
    assign obs1_x = screen_width - scrolladdr + obstacle_offset;
    assign obs2_x = obs1_x + OBSTACLE_GAP;

    // Both plaques stand on the floor
    assign rows_hit = (vaddr_ext >= obstacle_top) && (vaddr_ext < FLOOR_Y);

    assign obs1_in = rows_hit && (haddr_ext >= obs1_x) && (haddr_ext < obs1_x + obstacle_w);
    assign obs2_in = rows_hit && (haddr_ext >= obs2_x) && (haddr_ext < obs2_x + obstacle_w);

    // First obstacle wins where both overlap
    assign sel_x   = obs1_in ? obs1_x : obs2_x;
    assign local_x = haddr_ext - sel_x;
    assign local_y = vaddr_ext - obstacle_top;

    // Two pixel black border on left, right and top
    assign outline = (local_x < 11'd2) || (local_x > obstacle_w - 11'd3) ||
                     (local_y < 11'd2);

    assign obstacle_hit = display_on && obstacle_active && (obs1_in || obs2_in);
    assign obstacle_rgb = palette(outline ? color_black : color_gold);

endmodule

// File: hw/layer_compositor.sv
module layer_compositor (
    input  logic                          clk,
    input  logic                          sys_rst,
    input  logic                          sky_hit,
    input  logic                          floor_hit,
    input  logic                          dot_hit,
    input  logic                          goose_hit,
    input  logic [render_pkg::rgb_w-1:0]  goose_rgb,
    input  logic                          obstacle_hit,
    input  logic [render_pkg::rgb_w-1:0]  obstacle_rgb,
    output logic [1:0]                    R,
    output logic [1:0]                    G,
    output logic [1:0]                    B,
    output logic                          collision
);
    import render_pkg::*;

    logic [layer_count-1:0] layers_q;
    logic [rgb_w-1:0]       goose_rgb_q;
    logic [rgb_w-1:0]       obstacle_rgb_q;
    logic [rgb_w-1:0]       pixel_rgb;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            layers_q <= '0;
        end else begin
            layers_q[layer_goose]    <= goose_hit;
            layers_q[layer_obstacle] <= obstacle_hit;
            layers_q[layer_floor]    <= floor_hit;
            layers_q[layer_sky]      <= sky_hit;
            layers_q[layer_dots]     <= dot_hit;
        end
    end

    // Sprite colours travel alongside the layer bits
    always_ff @(posedge clk) begin
        goose_rgb_q    <= goose_rgb;
        obstacle_rgb_q <= obstacle_rgb;
    end

    // Front to back: goose, obstacle, dots, floor, sky
    always_comb begin
        pixel_rgb = '0;
        if (layers_q[layer_goose]) begin
            pixel_rgb = goose_rgb_q;
        end else if (layers_q[layer_obstacle]) begin
            pixel_rgb = obstacle_rgb_q;
        end else if (layers_q[layer_dots]) begin
            pixel_rgb = dot_rgb;
        end else if (layers_q[layer_floor]) begin
            pixel_rgb = floor_rgb;
        end else if (layers_q[layer_sky]) begin
            pixel_rgb = sky_rgb;
        end
    end

    assign R = pixel_rgb[5:4];
    assign G = pixel_rgb[3:2];
    assign B = pixel_rgb[1:0];

    // Opaque goose over opaque obstacle
    assign collision = layers_q[layer_goose] & layers_q[layer_obstacle];

endmodule

// File: hw/rendering.sv
module rendering #(
    parameter logic [render_pkg::coord_w-1:0] FLOOR_Y      = 11'd240,
    parameter logic [render_pkg::coord_w-1:0] OBSTACLE_GAP = 11'd344
) (
    input  logic                            clk,
    input  logic                            sys_rst,
    input  logic [9:0]                      haddr,
    input  logic [9:0]                      vaddr,
    input  logic [render_pkg::coord_w-1:0]  scrolladdr,
    input  logic [6:0]                      jump_pos,
    input  logic                            display_on,
    input  logic                            game_over,
    input  logic                            game_start_blink,
    input  logic                            obstacle_active,
    output logic [1:0]                      R,
    output logic [1:0]                      G,
    output logic [1:0]                      B,
    output logic                            collision
);
    import render_pkg::*;

    logic             sky_hit;
    logic             floor_hit;
    logic             dot_hit;
    logic             goose_hit;
    logic [rgb_w-1:0] goose_rgb;
    logic             obstacle_hit;
    logic [rgb_w-1:0] obstacle_rgb;

    backdrop #(
        .FLOOR_Y (FLOOR_Y)
    ) i_backdrop (
        .haddr, .vaddr, .scrolladdr, .display_on,
        .sky_hit, .floor_hit, .dot_hit
    );

    goose_sprite #(
        .FLOOR_Y (FLOOR_Y)
    ) i_goose_sprite (
        .haddr, .vaddr, .jump_pos, .display_on, .game_start_blink, .game_over,
        .goose_hit, .goose_rgb
    );

    obstacle_plaque #(
        .FLOOR_Y      (FLOOR_Y),
        .OBSTACLE_GAP (OBSTACLE_GAP)
    ) i_obstacle_plaque (
        .haddr, .vaddr, .scrolladdr, .display_on, .obstacle_active,
        .obstacle_hit, .obstacle_rgb
    );

    // Single register stage between the raster inputs and the pixel outputs
    layer_compositor i_layer_compositor (
        .clk, .sys_rst,
        .sky_hit, .floor_hit, .dot_hit,
        .goose_hit, .goose_rgb, .obstacle_hit, .obstacle_rgb,
        .R, .G, .B, .collision
    );

endmodule

// File: testbench/tb_rendering.sv
module tb_rendering;
    timeunit 1ns;
    timeprecision 1ps;

    // About 900 cycles of tests, so the limit leaves a wide margin
    localparam int timeout_cycles = 20000;
    localparam int floor_row      = 240;
    localparam int plaque_top     = 192;
    localparam logic [31:0] lfsr_seed = 32'hb141bf9f;

    // Expected colours as {R, G, B}
    localparam logic [5:0] sky_rgb   = 6'b00_11_11;
    localparam logic [5:0] floor_rgb = 6'b01_01_01;
    localparam logic [5:0] dot_rgb   = 6'b10_10_10;
    localparam logic [5:0] body_rgb  = 6'b10_10_01;
    localparam logic [5:0] black_rgb = 6'b00_00_00;
    localparam logic [5:0] beak_rgb  = 6'b11_10_01;
    localparam logic [5:0] gold_rgb  = 6'b11_10_00;
    localparam logic [5:0] red_rgb   = 6'b10_00_00;

    logic        clk;
    logic        sys_rst;
    logic [9:0]  haddr;
    logic [9:0]  vaddr;
    logic [10:0] scrolladdr;
    logic [6:0]  jump_pos;
    logic        display_on;
    logic        game_over;
    logic        game_start_blink;
    logic        obstacle_active;
    logic [1:0]  R;
    logic [1:0]  G;
    logic [1:0]  B;
    logic        collision;
    logic [31:0] lfsr;
    int          cycle_count = 0;

    rendering i_rendering (
        .clk, .sys_rst, .haddr, .vaddr, .scrolladdr, .jump_pos,
        .display_on, .game_over, .game_start_blink, .obstacle_active,
        .R, .G, .B, .collision
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // Backdrop plus obstacles, the goose hidden
    function automatic logic [5:0] scene_rgb(input int h, input int v, input int s,
                                             input logic active);
        logic [5:0] rgb;
        int         e1;
        int         e2;
        int         lx;
        if (v < floor_row) begin
            rgb = sky_rgb;
        end else if (v == floor_row && (h + s) % 16 >= 2 && (h + s) % 16 <= 5) begin
            rgb = dot_rgb;
        end else begin
            rgb = floor_rgb;
        end
        // Screen width 640 plus start offset 334, modulo 2048
        e1 = (974 - s) & 2047;
        e2 = (e1 + 344) & 2047;
        lx = -1;
        if (h >= e1 && h < e1 + 40) begin
            lx = h - e1;
        end else if (h >= e2 && h < e2 + 40) begin
            lx = h - e2;
        end
        if (active && v >= plaque_top && v < floor_row && lx >= 0) begin
            rgb = (lx < 2 || lx > 37 || v < plaque_top + 2) ? black_rgb : gold_rgb;
        end
        return rgb;
    endfunction

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        assert (got == exp) else begin
            $display("Mismatch %s at haddr %0d vaddr %0d: expected 0x%h, got 0x%h",
                     name, haddr, vaddr, exp, got);
            abort_run();
        end
    endtask

    task automatic check_outputs(input logic [5:0] exp_rgb, input logic exp_coll);
        compare_value("R", {6'd0, R}, {6'd0, exp_rgb[5:4]});
        compare_value("G", {6'd0, G}, {6'd0, exp_rgb[3:2]});
        compare_value("B", {6'd0, B}, {6'd0, exp_rgb[1:0]});
        compare_value("collision", {7'd0, collision}, {7'd0, exp_coll});
    endtask

    // One cycle from the driving edge to the registered output
    task automatic check_pixel(input int h, input int v, input logic [5:0] exp_rgb,
                               input logic exp_coll);
        @(negedge clk);
        haddr = 10'(h);
        vaddr = 10'(v);
        @(negedge clk);
        check_outputs(exp_rgb, exp_coll);
    endtask

    task automatic test_reset_blanking();
        int i;
        int h;
        int v;
        scrolladdr = 11'd914;
        haddr      = 10'd70;
        vaddr      = 10'd232;
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            check_outputs(6'd0, 1'b0);
        end
        sys_rst    = 1'b0;
        display_on = 1'b0;
        check_pixel(70, 232, 6'd0, 1'b0);
        check_pixel(80, 200, 6'd0, 1'b0);
        for (i = 0; i < 16; i++) begin
            draw_bits(10, h);
            draw_bits(9, v);
            check_pixel(h, v, 6'd0, 1'b0);
        end
    endtask

    task automatic test_backdrop();
        int i;
        int h;
        int v;
        int s;
        display_on       = 1'b1;
        obstacle_active  = 1'b0;
        game_start_blink = 1'b0;
        for (i = 0; i < 24; i++) begin
            draw_bits(10, h);
            draw_bits(8, v);
            check_pixel(h % 640, v % floor_row, sky_rgb, 1'b0);
            draw_bits(9, v);
            check_pixel(h % 640, floor_row + 1 + v % 239, floor_rgb, 1'b0);
        end
        for (i = 0; i < 3; i++) begin
            draw_bits(11, s);
            scrolladdr = 11'(s);
            for (h = 0; h < 32; h++) begin
                check_pixel(h, floor_row, scene_rgb(h, floor_row, s, 1'b0), 1'b0);
            end
        end
    endtask

    // Opaque ROM rows 12 and 3 plus their transparent neighbours
    task automatic check_goose(input int jump, input logic over);
        logic [5:0] body;
        logic [5:0] head;
        logic [5:0] beak;
        int         top;
        int         h;
        body             = over ? red_rgb : body_rgb;
        head             = over ? red_rgb : black_rgb;
        beak             = over ? red_rgb : beak_rgb;
        top              = floor_row - 32 - jump;
        jump_pos         = 7'(jump);
        game_over        = over;
        game_start_blink = 1'b1;
        for (h = 68; h <= 89; h++) begin
            check_pixel(h, top + 24, body, 1'b0);
        end
        check_pixel(64, top + 24, sky_rgb, 1'b0);
        check_pixel(90, top + 24, sky_rgb, 1'b0);
        for (h = 84; h <= 93; h++) begin
            check_pixel(h, top + 6, head, 1'b0);
        end
        check_pixel(94, top + 6, beak, 1'b0);
        check_pixel(83, top + 6, sky_rgb, 1'b0);
    endtask

    task automatic test_goose();
        check_goose(0, 1'b0);
        check_goose(10, 1'b0);
        game_start_blink = 1'b0;
        check_pixel(70, 222, sky_rgb, 1'b0);
        check_pixel(94, 204, sky_rgb, 1'b0);
        jump_pos = 7'd0;
        check_pixel(70, 232, sky_rgb, 1'b0);
        check_pixel(94, 214, sky_rgb, 1'b0);
    endtask

    task automatic test_game_over();
        check_goose(0, 1'b1);
        check_goose(10, 1'b1);
        game_over = 1'b0;
        jump_pos  = 7'd0;
    endtask

    task automatic test_obstacle();
        int i;
        int s;
        int e;
        int h;
        int v;
        obstacle_active  = 1'b1;
        game_start_blink = 1'b0;
        scrolladdr       = 11'd914;
        check_pixel(60, 200, black_rgb, 1'b0);
        check_pixel(61, 200, black_rgb, 1'b0);
        check_pixel(62, 200, gold_rgb, 1'b0);
        check_pixel(97, 220, gold_rgb, 1'b0);
        check_pixel(99, 220, black_rgb, 1'b0);
        check_pixel(80, 192, black_rgb, 1'b0);
        check_pixel(80, 193, black_rgb, 1'b0);
        check_pixel(80, 194, gold_rgb, 1'b0);
        check_pixel(404, 200, black_rgb, 1'b0);
        check_pixel(420, 230, gold_rgb, 1'b0);
        check_pixel(80, 191, sky_rgb, 1'b0);
        check_pixel(404, 191, sky_rgb, 1'b0);
        for (i = 0; i < 32; i++) begin
            draw_bits(11, s);
            scrolladdr = 11'(s);
            e = (974 - s) & 2047;
            if (e < 984) begin
                check_pixel(e, 210, black_rgb, 1'b0);
                check_pixel(e + 20, 220, gold_rgb, 1'b0);
                check_pixel(e + 39, 230, black_rgb, 1'b0);
            end
            draw_bits(10, h);
            draw_bits(6, v);
            check_pixel(h, 180 + v, scene_rgb(h, 180 + v, s, 1'b1), 1'b0);
        end
    endtask

    task automatic test_collision();
        scrolladdr       = 11'd914;
        obstacle_active  = 1'b1;
        game_start_blink = 1'b1;
        jump_pos         = 7'd0;
        check_pixel(70, 232, body_rgb, 1'b1);
        check_pixel(64, 232, gold_rgb, 1'b0);
        obstacle_active = 1'b0;
        check_pixel(70, 232, body_rgb, 1'b0);
    endtask

    initial begin
        sys_rst          = 1'b1;
        haddr            = 10'd0;
        vaddr            = 10'd0;
        scrolladdr       = 11'd0;
        jump_pos         = 7'd0;
        display_on       = 1'b1;
        game_over        = 1'b0;
        game_start_blink = 1'b1;
        obstacle_active  = 1'b1;
        lfsr             = lfsr_seed;
        test_reset_blanking();
        test_backdrop();
        test_goose();
        test_game_over();
        test_obstacle();
        test_collision();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: goose_render.f
hw/render_pkg.sv
hw/backdrop.sv
hw/goose_sprite.sv
hw/obstacle_plaque.sv
hw/layer_compositor.sv
hw/rendering.sv
testbench/tb_rendering.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; a failing run exits non-zero
cd "$(dirname "$0")" &&
    verilator --binary --timing -Wno-fatal --top-module tb_rendering \
        -f goose_render.f &&
    ./obj_dir/Vtb_rendering || exit 1
